// File: spinner_pkg.sv
// Spinner input package
// Shared widths, quadrature phase encoding, PS/2 key codes,
// joystick bit positions and D-pad step sizes

package spinner_pkg;

	typedef logic signed [11:0] pos_t;	// Pending movement in encoder edges
	typedef logic signed [11:0] delta_t;	// Signed step into the accumulator
	typedef logic [7:0]         key_code_t;	// PS/2 scan code
	typedef logic [31:0]        joy_t;	// Host joystick button word

	// AB output of the spinner, named by bit pattern
	typedef enum logic [1:0] {
		PH_11 = 2'b11,
		PH_10 = 2'b10,
		PH_00 = 2'b00,
		PH_01 = 2'b01
	} quad_phase_t;

	////////////////////////////////////////////////////////////
	// Key codes, set 2 make codes
	localparam key_code_t KEY_START1  = 8'h16;	// 1
	localparam key_code_t KEY_START2  = 8'h1E;	// 2
	localparam key_code_t KEY_COIN1   = 8'h2E;	// 5
	localparam key_code_t KEY_COIN2   = 8'h36;	// 6
	localparam key_code_t KEY_SERVICE = 8'h46;	// 9
	localparam key_code_t KEY_FAST    = 8'h11;	// Alt
	localparam key_code_t KEY_LEFT    = 8'h6B;	// Cursor left
	localparam key_code_t KEY_RIGHT   = 8'h74;	// Cursor right
	localparam key_code_t KEY_FIRE    = 8'h29;	// Space

	// Joystick bit positions
	localparam int JOY_RIGHT  = 0;
	localparam int JOY_LEFT   = 1;
	localparam int JOY_FIRE   = 4;
	localparam int JOY_FAST   = 5;
	localparam int JOY_START1 = 6;
	localparam int JOY_COIN1  = 7;
	localparam int JOY_START2 = 8;

	// Edges per D-pad repeat
	localparam delta_t DPAD_STEP_SLOW = 12'sd4;
	localparam delta_t DPAD_STEP_FAST = 12'sd9;

endpackage

// File: control_decoder.sv
// Player control decoder
// PS/2 keyboard events and joystick bits become active-low button strobes.
// Mouse X motion and held D-pad directions become signed movement steps.
`timescale 1ns/100ps

module control_decoder #(
	parameter int REPEAT_CYCLES = 384000	// D-pad repeat period in clocks
) (
	input  logic                CLK_48M,
	input  logic                rst_n,
	input  logic [10:0]         ps2_key,	// Toggle, pressed, code
	input  logic [24:0]         ps2_mouse,	// Toggle, X, sign, buttons
	input  spinner_pkg::joy_t   joy,
	output logic                fire_n,
	output logic                start1_n,
	output logic                start2_n,
	output logic                coin1_n,
	output logic                coin2_n,
	output logic                service_n,
	output logic                step_valid,	// One cycle pulse
	output spinner_pkg::delta_t step_delta
);

	localparam int REP_W = $clog2(REPEAT_CYCLES);

	////////////////////////////////////////////////////////////
	// Keyboard

	spinner_pkg::key_code_t key_code;
	logic key_pressed;
	logic key_tgl_q;
	logic key_event;

	logic btn_fire, btn_fast, btn_left, btn_right;
	logic btn_start1, btn_start2, btn_coin1, btn_coin2, btn_service;

	assign key_code    = ps2_key[7:0];
	assign key_pressed = ps2_key[9];	// 1 on make, 0 on break
	assign key_event   = ps2_key[10] ^ key_tgl_q;	// Host flips bit 10 per event

	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			key_tgl_q   <= ps2_key[10];	// No event out of reset
			btn_fire    <= 1'b0;
			btn_fast    <= 1'b0;
			btn_left    <= 1'b0;
			btn_right   <= 1'b0;
			btn_start1  <= 1'b0;
			btn_start2  <= 1'b0;
			btn_coin1   <= 1'b0;
			btn_coin2   <= 1'b0;
			btn_service <= 1'b0;
		end else begin
			key_tgl_q <= ps2_key[10];
			if (key_event) begin
				case (key_code)
					spinner_pkg::KEY_START1:  btn_start1  <= key_pressed;
					spinner_pkg::KEY_START2:  btn_start2  <= key_pressed;
					spinner_pkg::KEY_COIN1:   btn_coin1   <= key_pressed;
					spinner_pkg::KEY_COIN2:   btn_coin2   <= key_pressed;
					spinner_pkg::KEY_SERVICE: btn_service <= key_pressed;
					spinner_pkg::KEY_FAST:    btn_fast    <= key_pressed;
					spinner_pkg::KEY_LEFT:    btn_left    <= key_pressed;
					spinner_pkg::KEY_RIGHT:   btn_right   <= key_pressed;
					spinner_pkg::KEY_FIRE:    btn_fire    <= key_pressed;
					default: ;	// Other keys ignored
				endcase
			end
		end
	end

	// Merged controls, active high
	logic m_fast, m_left, m_right;

	assign m_fast  = btn_fast  | joy[spinner_pkg::JOY_FAST];
	assign m_left  = btn_left  | joy[spinner_pkg::JOY_LEFT];
	assign m_right = btn_right | joy[spinner_pkg::JOY_RIGHT];

	// Board side strobes are active low
	assign fire_n    = ~(btn_fire | joy[spinner_pkg::JOY_FIRE] | (|ps2_mouse[1:0]));
	assign start1_n  = ~(btn_start1 | joy[spinner_pkg::JOY_START1]);
	assign start2_n  = ~(btn_start2 | joy[spinner_pkg::JOY_START2]);
	assign coin1_n   = ~(btn_coin1 | joy[spinner_pkg::JOY_COIN1]);
	assign coin2_n   = ~btn_coin2;	// Keyboard only
	assign service_n = ~btn_service;

	////////////////////////////////////////////////////////////
	// Movement steps

	logic mouse_tgl_q;
	logic mouse_event;
	spinner_pkg::delta_t mouse_delta;
	logic [REP_W-1:0] rep_cnt;
	logic dpad_held;
	logic dpad_fire;
	spinner_pkg::delta_t dpad_step;
	spinner_pkg::delta_t dpad_delta;

	assign mouse_event = ps2_mouse[24] ^ mouse_tgl_q;
	// X is 9 bit two's complement, sign in bit 4
	assign mouse_delta = {{4{ps2_mouse[4]}}, ps2_mouse[15:8]};

	assign dpad_held  = m_left | m_right;
	assign dpad_fire  = dpad_held && (rep_cnt == REP_W'(REPEAT_CYCLES - 1));
	assign dpad_step  = m_fast ? spinner_pkg::DPAD_STEP_FAST : spinner_pkg::DPAD_STEP_SLOW;
	assign dpad_delta = m_right ? dpad_step : -dpad_step;	// Right wins if both held

	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			mouse_tgl_q <= ps2_mouse[24];
			rep_cnt     <= '0;
			step_valid  <= 1'b0;
		end else begin
			mouse_tgl_q <= ps2_mouse[24];
			step_valid  <= mouse_event | dpad_fire;
			if (!dpad_held || dpad_fire)
				rep_cnt <= '0;	// Idle or period done
			else
				rep_cnt <= rep_cnt + REP_W'(1);
		end
	end

	// Step value, mouse first when both land together
	always_ff @(posedge CLK_48M) begin
		if (mouse_event)
			step_delta <= mouse_delta;
		else if (dpad_fire)
			step_delta <= dpad_delta;
	end

endmodule

// File: position_accumulator.sv
// Spinner position accumulator
// Holds signed movement not yet sent to the encoder. Adds decoder steps
// and moves one unit toward zero each time the encoder emits an edge.
`timescale 1ns/100ps

module position_accumulator (
	input  logic                CLK_48M,
	input  logic                rst_n,
	input  logic                step_valid,
	input  spinner_pkg::delta_t step_delta,
	input  logic                drain,	// One edge sent
	output logic                pending,	// Position nonzero
	output logic                pending_neg	// Position below zero
);

	spinner_pkg::pos_t pos;
	spinner_pkg::pos_t pos_drained;
	spinner_pkg::pos_t pos_nxt;
	logic add_ok;

	// Refuse steps once the top two bits split, keeps the sum in range
	assign add_ok = ~(pos[11] ^ pos[10]);

	////////////////////////////////////////////////////////////
	// Next position

	always_comb begin
		pos_drained = pos;
		if (drain) begin
			if (pos[11])
				pos_drained = pos + spinner_pkg::pos_t'(1);	// Negative, count up
			else
				pos_drained = pos - spinner_pkg::pos_t'(1);
		end

		pos_nxt = pos_drained;
		if (step_valid && add_ok)
			pos_nxt = pos_drained + step_delta;	// Drain and step both apply
	end

	always_ff @(posedge CLK_48M) begin
		if (!rst_n)
			pos <= '0;
		else
			pos <= pos_nxt;
	end

	// Status seen by the encoder
	assign pending     = (pos != '0);
	assign pending_neg = pos[11];

endmodule

// File: quadrature_encoder.sv
// Quadrature spinner encoder
// Emits one AB phase step per tick while movement is pending, walking
// the phase in the direction of the pending sign, and reports each
// step back to the accumulator as a drain pulse
`timescale 1ns/100ps

module quadrature_encoder #(
	parameter int TICK_CYCLES = 12000	// Clocks per encoder edge
) (
	input  logic                     CLK_48M,
	input  logic                     rst_n,
	input  logic                     pending,
	input  logic                     pending_neg,
	output logic                     drain,	// Edge emitted this cycle
	output spinner_pkg::quad_phase_t spinner	// AB to the board
);

	localparam int TICK_W = $clog2(TICK_CYCLES);

	logic [TICK_W-1:0] tick_cnt;
	logic tick;
	spinner_pkg::quad_phase_t phase;
	spinner_pkg::quad_phase_t phase_nxt;

	////////////////////////////////////////////////////////////
	// Edge rate

	assign tick = (tick_cnt == TICK_W'(TICK_CYCLES - 1));

	always_ff @(posedge CLK_48M) begin
		if (!rst_n)
			tick_cnt <= '0;
		else if (tick)
			tick_cnt <= '0;	// Free running, wraps every period
		else
			tick_cnt <= tick_cnt + TICK_W'(1);
	end

	// Only step when there is something left to send
	assign drain = tick & pending;

	////////////////////////////////////////////////////////////
	// Phase FSM

	always_comb begin
		phase_nxt = phase;
		if (pending_neg) begin
			// Negative: 11 -> 10 -> 00 -> 01
			case (phase)
				spinner_pkg::PH_11: phase_nxt = spinner_pkg::PH_10;
				spinner_pkg::PH_10: phase_nxt = spinner_pkg::PH_00;
				spinner_pkg::PH_00: phase_nxt = spinner_pkg::PH_01;
				spinner_pkg::PH_01: phase_nxt = spinner_pkg::PH_11;
				default:            phase_nxt = spinner_pkg::PH_11;
			endcase
		end else begin
			// Positive: 11 -> 01 -> 00 -> 10
			case (phase)
				spinner_pkg::PH_11: phase_nxt = spinner_pkg::PH_01;
				spinner_pkg::PH_01: phase_nxt = spinner_pkg::PH_00;
				spinner_pkg::PH_00: phase_nxt = spinner_pkg::PH_10;
				spinner_pkg::PH_10: phase_nxt = spinner_pkg::PH_11;
				default:            phase_nxt = spinner_pkg::PH_11;
			endcase
		end
	end

	always_ff @(posedge CLK_48M) begin
		if (!rst_n)
			phase <= spinner_pkg::PH_11;	// Rest position of the spinner
		else if (drain)
			phase <= phase_nxt;
	end

	assign spinner = phase;

endmodule

// File: spinner_top.sv
// Spinner input top level
// Decoder feeds signed steps into the accumulator, the encoder drains
// the accumulator one quadrature edge per tick toward the game board
`timescale 1ns/100ps

module spinner_top #(
	parameter int REPEAT_CYCLES = 384000,	// About 8 ms at 48 MHz
	parameter int TICK_CYCLES   = 12000	// About 4 kHz edge rate
) (
	input  logic                     CLK_48M,
	input  logic                     rst_n,
	input  logic [10:0]              ps2_key,
	input  logic [24:0]              ps2_mouse,
	input  spinner_pkg::joy_t        joy,
	output spinner_pkg::quad_phase_t spinner,
	output logic                     fire_n,
	output logic                     start1_n,
	output logic                     start2_n,
	output logic                     coin1_n,
	output logic                     coin2_n,
	output logic                     service_n
);

	logic                step_valid;
	spinner_pkg::delta_t step_delta;
	logic                pending;
	logic                pending_neg;
	logic                drain;

	////////////////////////////////////////////////////////////
	// Producer, buffer, consumer

	control_decoder #(
		.REPEAT_CYCLES (REPEAT_CYCLES)
	) u_control_decoder (
		.CLK_48M    (CLK_48M),
		.rst_n      (rst_n),
		.ps2_key    (ps2_key),
		.ps2_mouse  (ps2_mouse),
		.joy        (joy),
		.fire_n     (fire_n),
		.start1_n   (start1_n),
		.start2_n   (start2_n),
		.coin1_n    (coin1_n),
		.coin2_n    (coin2_n),
		.service_n  (service_n),
		.step_valid (step_valid),
		.step_delta (step_delta)
	);

	position_accumulator u_position_accumulator (
		.CLK_48M     (CLK_48M),
		.rst_n       (rst_n),
		.step_valid  (step_valid),
		.step_delta  (step_delta),
		.drain       (drain),
		.pending     (pending),
		.pending_neg (pending_neg)
	);

	quadrature_encoder #(
		.TICK_CYCLES (TICK_CYCLES)
	) u_quadrature_encoder (
		.CLK_48M     (CLK_48M),
		.rst_n       (rst_n),
		.pending     (pending),
		.pending_neg (pending_neg),
		.drain       (drain),
		.spinner     (spinner)
	);

endmodule

// File: spinner_assert.sv
// Spinner checks
// Drain only with pending movement, single-bit phase steps,
// and no pending movement right after reset
`timescale 1ns/100ps

module spinner_assert (
	input logic       CLK_48M,
	input logic       rst_n,
	input logic       pending,	// From the accumulator
	input logic       drain,
	input logic [1:0] spinner
);

	a_drain_pending: assert property (@(posedge CLK_48M) disable iff (!rst_n)
		drain |-> pending)
		else $error("drain pulsed with no pending movement");

	// Gray steps only
	a_phase_adjacent: assert property (@(posedge CLK_48M) disable iff (!rst_n)
		(spinner != $past(spinner)) |-> ($countones(spinner ^ $past(spinner)) == 1))
		else $error("spinner moved to a non-adjacent phase");

	a_reset_idle: assert property (@(posedge CLK_48M) !rst_n |=> !pending)
		else $error("pending high after reset");

endmodule

bind quadrature_encoder spinner_assert u_spinner_assert (
	.CLK_48M (CLK_48M),
	.rst_n   (rst_n),
	.pending (pending),
	.drain   (drain),
	.spinner (spinner)
);

// File: tb_spinner_tasks.svh
// Spinner testbench tasks
// Value check, input drivers and the directed tests

task automatic check(input string name, input int expected, input int actual);
	num_checks++;
	if (expected != actual) begin
		num_errors++;
		$display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
	end
endtask

task automatic finish_test(input string name, input int err_start);
	$display("%-8s done, %0d failures", name, num_errors - err_start);
endtask

////////////////////////////////////////////////////////////
// Input drivers on the falling edge

task automatic send_key(input spinner_pkg::key_code_t code, input logic pressed);
	@(negedge CLK_48M);
	ps2_key = {~ps2_key[10], pressed, 1'b0, code};	// Flip toggle per event
endtask

task automatic send_mouse(input int d);
	@(negedge CLK_48M);
	ps2_mouse[15:8] = d[7:0];	// Low byte of 9 bit X
	ps2_mouse[4]    = (d < 0);
	ps2_mouse[24]   = ~ps2_mouse[24];
endtask

// Wait until no movement is left
task automatic wait_drained(input string name);
	int cycles;
	cycles = 0;
	repeat (4) @(negedge CLK_48M);	// Pending rises 2 cycles after the event
	while (u_spinner_top.pending && cycles < DRAIN_LIMIT) begin
		@(negedge CLK_48M);
		cycles++;
	end
	@(negedge CLK_48M);	// Last edge and pending fall share a clock edge
	if (u_spinner_top.pending) begin
		num_errors++;
		$display("%s: spinner still moving after %0d cycles", name, cycles);
	end
endtask

task automatic key_button(input spinner_pkg::key_code_t code, input int mask);
	send_key(code, 1'b1);
	@(negedge CLK_48M);	// One cycle of latency
	check("buttons key make", 63 ^ mask, int'(strobes));
	send_key(code, 1'b0);
	@(negedge CLK_48M);
	check("buttons key break", 63, int'(strobes));
endtask

task automatic joy_button(input int joy_bit, input int mask);
	@(negedge CLK_48M);
	joy = '0;
	joy[joy_bit] = 1'b1;
	@(negedge CLK_48M);
	check("buttons joy press", 63 ^ mask, int'(strobes));
	joy = '0;
	@(negedge CLK_48M);
	check("buttons joy release", 63, int'(strobes));
endtask

////////////////////////////////////////////////////////////
// Directed tests

task automatic test_reset();
	int err_start;
	err_start = num_errors;
	@(negedge CLK_48M);
	check("reset spinner", 3, int'(spinner));	// Phase 11
	check("reset strobes", 63, int'(strobes));
	check("reset pending", 0, int'(u_spinner_top.pending));
	finish_test("reset", err_start);
endtask

task automatic test_buttons();
	int err_start;
	err_start = num_errors;
	key_button(8'h29, 32);	// Fire
	key_button(8'h16, 16);	// Start 1
	key_button(8'h1E, 8);	// Start 2
	key_button(8'h2E, 4);	// Coin 1
	key_button(8'h36, 2);	// Coin 2
	key_button(8'h46, 1);	// Service
	joy_button(4, 32);
	joy_button(6, 16);
	joy_button(8, 8);
	joy_button(7, 4);
	@(negedge CLK_48M);
	ps2_mouse[0] = 1'b1;	// Left mouse button is fire too
	@(negedge CLK_48M);
	check("buttons mouse", 31, int'(strobes));
	ps2_mouse[0] = 1'b0;
	finish_test("buttons", err_start);
endtask

task automatic test_mouse();
	int err_start, base, sum, m, i;
	err_start = num_errors;
	base      = net_edges;
	sum       = 0;
	for (i = 0; i < MOUSE_MOVES; i++) begin
		m = int'($urandom_range(60, 1));
		if ($urandom_range(1, 0) == 0)
			m = -m;
		sum += m;
		send_mouse(m);
		wait_drained("mouse");
		check("mouse net edges", sum, net_edges - base);
	end
	finish_test("mouse", err_start);
endtask

task automatic dpad_run(input logic right, input logic fast);
	int base, step;
	spinner_pkg::key_code_t dir;
	base = net_edges;
	step = fast ? 9 : 4;	// Edges per repeat
	dir  = right ? 8'h74 : 8'h6B;
	if (fast)
		send_key(8'h11, 1'b1);
	send_key(dir, 1'b1);
	repeat (2 * REPEAT_CYCLES + $urandom_range(DPAD_HOLD_MAX - 2 * REPEAT_CYCLES, 0))
		@(negedge CLK_48M);
	send_key(dir, 1'b0);	// Direction first so the step size holds
	if (fast)
		send_key(8'h11, 1'b0);
	wait_drained("dpad");
	check("dpad step size", 0, (net_edges - base) % step);
	if (right)
		check("dpad right", 1, (net_edges - base > 0) ? 1 : 0);
	else
		check("dpad left", 1, (net_edges - base < 0) ? 1 : 0);
endtask

task automatic test_dpad();
	int err_start;
	err_start = num_errors;
	dpad_run(1'b1, 1'b0);
	dpad_run(1'b1, 1'b1);
	dpad_run(1'b0, 1'b0);
	dpad_run(1'b0, 1'b1);
	finish_test("dpad", err_start);
endtask

// Steps land while the encoder is still draining
task automatic test_mixed();
	int err_start, base, sum, m, i;
	err_start = num_errors;
	base      = net_edges;
	sum       = 0;
	for (i = 0; i < MIX_STEPS; i++) begin
		m = int'($urandom_range(60, 1));
		if (i % 2 == 1)
			m = -m;	// Alternate signs
		sum += m;
		send_mouse(m);
		repeat ($urandom_range(40, 5)) @(negedge CLK_48M);
	end
	wait_drained("mixed");
	check("mixed net edges", sum, net_edges - base);
	finish_test("mixed", err_start);
endtask

// File: tb_spinner.sv
// Spinner input testbench
// Drives keyboard, mouse and joystick events into the spinner top level
// and counts the quadrature edges seen on the spinner output
`timescale 1ns/100ps

module tb_spinner;

	localparam int REPEAT_CYCLES = 64;	// D-pad repeat, clocks
	localparam int TICK_CYCLES   = 8;	// Clocks per encoder edge
	localparam int MOUSE_MOVES   = 8;
	localparam int MIX_STEPS     = 6;
	localparam int DPAD_HOLD_MAX = 6 * REPEAT_CYCLES;
	localparam int DRAIN_LIMIT   = 400 * TICK_CYCLES;	// Longest wait for pending to clear
	// Worst case length of each test, doubled for margin
	localparam int WATCHDOG_CYCLES = 2 * (16 + 64
		+ MOUSE_MOVES * (60 * TICK_CYCLES + 16)
		+ 4 * (DPAD_HOLD_MAX + 60 * TICK_CYCLES + 16)
		+ MIX_STEPS * (60 * TICK_CYCLES + 40) + DRAIN_LIMIT);

	logic                     CLK_48M;
	logic                     rst_n;
	logic [10:0]              ps2_key;
	logic [24:0]              ps2_mouse;
	spinner_pkg::joy_t        joy;
	spinner_pkg::quad_phase_t spinner;
	logic fire_n, start1_n, start2_n, coin1_n, coin2_n, service_n;
	logic [5:0]               strobes;	// Fire in bit 5, service in bit 0

	int num_checks;
	int num_errors;
	int phase_errors;	// Illegal jumps seen by the monitor
	int net_edges;	// Signed edge count, forward positive
	int edge_step;
	spinner_pkg::quad_phase_t prev_phase;

	assign strobes = {fire_n, start1_n, start2_n, coin1_n, coin2_n, service_n};

	spinner_top #(
		.REPEAT_CYCLES (REPEAT_CYCLES),
		.TICK_CYCLES   (TICK_CYCLES)
	) u_spinner_top (
		.CLK_48M   (CLK_48M),
		.rst_n     (rst_n),
		.ps2_key   (ps2_key),
		.ps2_mouse (ps2_mouse),
		.joy       (joy),
		.spinner   (spinner),
		.fire_n    (fire_n),
		.start1_n  (start1_n),
		.start2_n  (start2_n),
		.coin1_n   (coin1_n),
		.coin2_n   (coin2_n),
		.service_n (service_n)
	);

	always #20 CLK_48M = ~CLK_48M;	// 25 MHz sim clock, period 40 ns

	`include "tb_spinner_tasks.svh"

	////////////////////////////////////////////////////////////
	// Spinner monitor

	// Position in the forward order 11, 01, 00, 10
	function automatic int phase_index(input logic [1:0] p);
		case (p)
			2'b11:   return 0;
			2'b01:   return 1;
			2'b00:   return 2;
			default: return 3;
		endcase
	endfunction

	always @(negedge CLK_48M) begin
		edge_step = (phase_index(spinner) - phase_index(prev_phase) + 4) % 4;
		if (edge_step == 1)
			net_edges++;	// Forward edge
		else if (edge_step == 3)
			net_edges--;	// Reverse edge
		else if (edge_step == 2) begin
			phase_errors++;
			$display("Spinner jumped over a phase at %0t", $time);
		end
		prev_phase = spinner;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK_48M);
		$display("Run stopped after %0d cycles, a test did not finish", WATCHDOG_CYCLES);
		$display("Test failures found");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		void'($urandom(56));
		CLK_48M      = 1'b0;
		rst_n        = 1'b0;
		ps2_key      = '0;
		ps2_mouse    = '0;
		joy          = '0;
		num_checks   = 0;
		num_errors   = 0;
		phase_errors = 0;
		net_edges    = 0;
		prev_phase   = spinner_pkg::PH_11;
		repeat (16) @(negedge CLK_48M);
		rst_n = 1'b1;

		test_reset();
		test_buttons();
		test_mouse();
		test_dpad();
		test_mixed();

		$display("%0d checks, %0d failures", num_checks, num_errors + phase_errors);
		if (num_errors + phase_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: compile.f
+incdir+.
spinner_pkg.sv
control_decoder.sv
position_accumulator.sv
quadrature_encoder.sv
spinner_top.sv
spinner_assert.sv
tb_spinner.sv

// File: run.sh
#!/bin/sh
# Build and run the spinner testbench with Verilator
verilator --binary --timing --assert --timescale 1ns/100ps -f compile.f \
	--top-module tb_spinner -Mdir obj_dir -o tb_spinner_sim > build.log 2>&1 \
	&& ./obj_dir/tb_spinner_sim > sim.log 2>&1 \
	|| { echo "Build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
